// File: common/hist_pkg.sv
`default_nettype none

package hist_pkg;

   // Defaults for the top-level parameters
   localparam int DEF_NUM_BINS     = 256;
   localparam int DEF_COUNT_WIDTH  = 32;
   localparam int DEF_SAMPLE_WIDTH = 16;

   localparam int WB_DATA_WIDTH = 32;

   // Wishbone slave handshake states
   typedef enum logic {
      wb_idle,
      wb_ack
   } wb_state_t;

   // Word addresses below the bin window, which starts at wb_adr[BIN_ADDR_WIDTH]
   localparam int REG_CTRL  = 0;  // Enable and shift amount
   localparam int REG_COUNT = 1;  // Accepted samples, a write clears it

   // Fields of REG_CTRL
   localparam int CTRL_ENABLE_BIT = 0;
   localparam int CTRL_SHIFT_LSB  = 4;
   localparam int SHIFT_WIDTH     = 4;

endpackage

`default_nettype wire

// File: hist_ram/fwd_hist_ram.sv
`timescale 1ns/100ps
`default_nettype none

module fwd_hist_ram
   import hist_pkg::*;
#(
   parameter int NUM_BINS    = DEF_NUM_BINS,
   parameter int COUNT_WIDTH = DEF_COUNT_WIDTH
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         wen,
   input  wire logic [$clog2(NUM_BINS)-1:0]  waddr,
   input  wire logic [COUNT_WIDTH-1:0]       wdata,
   input  wire logic [$clog2(NUM_BINS)-1:0]  raddr,
   output logic      [COUNT_WIDTH-1:0]       rdata,
   input  wire logic [$clog2(NUM_BINS)-1:0]  dbg_waddr,
   input  wire logic [COUNT_WIDTH-1:0]       dbg_wdata,
   input  wire logic                         dbg_wen,
   input  wire logic [$clog2(NUM_BINS)-1:0]  dbg_addr,
   output logic      [COUNT_WIDTH-1:0]       dbg_rdata
);

   localparam int BIN_ADDR_WIDTH = $clog2(NUM_BINS);

   logic [COUNT_WIDTH-1:0]    mem [NUM_BINS];

   logic                      mem_we;
   logic [BIN_ADDR_WIDTH-1:0] mem_waddr;
   logic [COUNT_WIDTH-1:0]    mem_wdata;

   logic [COUNT_WIDTH-1:0]    rdata_q;
   logic                      fwd_flag;
   logic [COUNT_WIDTH-1:0]    fwd_data;

   // The debug port wins when both ports write in the same cycle
   assign mem_we    = wen | dbg_wen;
   assign mem_waddr = dbg_wen ? dbg_waddr : waddr;
   assign mem_wdata = dbg_wen ? dbg_wdata : wdata;

   always_ff @(posedge clk) begin
      if (mem_we) begin
         mem[mem_waddr] <= mem_wdata;
      end
      rdata_q  <= mem[raddr];  // Old array value when the same word is written now
      fwd_data <= mem_wdata;
   end

   // Remember that the registered read missed this cycle's write
   always_ff @(posedge clk) begin
      if (rst) begin
         fwd_flag <= 1'b0;
      end else begin
         fwd_flag <= mem_we && (mem_waddr == raddr);
      end
   end

   assign rdata = fwd_flag ? fwd_data : rdata_q;

   assign dbg_rdata = mem[dbg_addr];  // Combinational, for the bus side only

endmodule

`default_nettype wire

// File: verilog/bin_mapper.sv
`timescale 1ns/100ps
`default_nettype none

module bin_mapper
   import hist_pkg::*;
#(
   parameter int NUM_BINS     = DEF_NUM_BINS,
   parameter int SAMPLE_WIDTH = DEF_SAMPLE_WIDTH
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         sample_valid,
   input  wire logic [SAMPLE_WIDTH-1:0]      sample_data,
   input  wire logic                         enable,
   input  wire logic [SHIFT_WIDTH-1:0]       shift,
   output logic                              sample_taken,
   output logic                              bin_valid,
   output logic      [$clog2(NUM_BINS)-1:0]  bin_index
);

   localparam int BIN_ADDR_WIDTH = $clog2(NUM_BINS);

   logic                      accept;
   logic [SAMPLE_WIDTH-1:0]   shifted;
   logic [BIN_ADDR_WIDTH-1:0] clamped;

   assign accept  = sample_valid & enable;  // Disabled samples are simply dropped
   assign shifted = sample_data >> shift;

   // Anything past the top bin is piled into the last bin
   always_comb begin
      if (int'(shifted) >= NUM_BINS) begin
         clamped = BIN_ADDR_WIDTH'(NUM_BINS - 1);
      end else begin
         clamped = shifted[BIN_ADDR_WIDTH-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         bin_valid <= 1'b0;
      end else begin
         bin_valid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         bin_index <= clamped;
      end
   end

   // One pulse per accepted sample, feeds the total counter in the slave
   assign sample_taken = bin_valid;

endmodule

`default_nettype wire

// File: verilog/hist_update.sv
`timescale 1ns/100ps
`default_nettype none

module hist_update
   import hist_pkg::*;
#(
   parameter int NUM_BINS    = DEF_NUM_BINS,
   parameter int COUNT_WIDTH = DEF_COUNT_WIDTH
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         bin_valid,
   input  wire logic [$clog2(NUM_BINS)-1:0]  bin_index,
   input  wire logic [$clog2(NUM_BINS)-1:0]  dbg_addr,
   input  wire logic [COUNT_WIDTH-1:0]       dbg_wdata,
   input  wire logic                         dbg_wen,
   output logic      [COUNT_WIDTH-1:0]       dbg_rdata
);

   localparam int BIN_ADDR_WIDTH = $clog2(NUM_BINS);

   // Write stage, one cycle behind the read address
   logic                      upd_valid;
   logic [BIN_ADDR_WIDTH-1:0] upd_index;

   logic [COUNT_WIDTH-1:0]    rd_count;
   logic [COUNT_WIDTH-1:0]    wr_count;

   always_ff @(posedge clk) begin
      if (rst) begin
         upd_valid <= 1'b0;
      end else begin
         upd_valid <= bin_valid;
      end
   end

   always_ff @(posedge clk) begin
      upd_index <= bin_index;
   end

   // A full counter stays at all ones
   always_comb begin
      if (rd_count == {COUNT_WIDTH{1'b1}}) begin
         wr_count = rd_count;
      end else begin
         wr_count = rd_count + 1'b1;
      end
   end

   // The read address follows bin_index directly. The count comes back a cycle later,
   // already corrected by the RAM when the previous sample hit the same bin
   fwd_hist_ram #(
      .NUM_BINS    (NUM_BINS),
      .COUNT_WIDTH (COUNT_WIDTH)
   ) u_ram (
      .clk       (clk),
      .rst       (rst),
      .wen       (upd_valid),
      .waddr     (upd_index),
      .wdata     (wr_count),
      .raddr     (bin_index),
      .rdata     (rd_count),
      .dbg_waddr (dbg_addr),
      .dbg_wdata (dbg_wdata),
      .dbg_wen   (dbg_wen),
      .dbg_addr  (dbg_addr),
      .dbg_rdata (dbg_rdata)
   );

endmodule

`default_nettype wire

// File: verilog/wb_hist_slave.sv
`timescale 1ns/100ps
`default_nettype none

module wb_hist_slave
   import hist_pkg::*;
#(
   parameter int NUM_BINS    = DEF_NUM_BINS,
   parameter int COUNT_WIDTH = DEF_COUNT_WIDTH
) (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         wb_cyc,
   input  wire logic                         wb_stb,
   input  wire logic                         wb_we,
   input  wire logic [$clog2(NUM_BINS):0]    wb_adr,
   input  wire logic [WB_DATA_WIDTH-1:0]     wb_dat_w,
   output logic      [WB_DATA_WIDTH-1:0]     wb_dat_r,
   output logic                              wb_ack,
   input  wire logic                         sample_taken,
   output logic                              enable,
   output logic      [SHIFT_WIDTH-1:0]       shift,
   output logic      [$clog2(NUM_BINS)-1:0]  dbg_addr,
   output logic      [COUNT_WIDTH-1:0]       dbg_wdata,
   output logic                              dbg_wen,
   input  wire logic [COUNT_WIDTH-1:0]       dbg_rdata
);

   localparam int BIN_ADDR_WIDTH = $clog2(NUM_BINS);

   // The port wb_ack hides the enum label of the same name, hence the package prefix
   wb_state_t                state;
   logic                     access;
   logic                     bin_sel;
   logic                     ctrl_sel;
   logic                     count_sel;
   logic [WB_DATA_WIDTH-1:0] sample_count;
   logic [WB_DATA_WIDTH-1:0] ctrl_word;
   logic [WB_DATA_WIDTH-1:0] rd_word;

   // A transfer is taken once, in the idle state
   assign access = (state == wb_idle) && wb_cyc && wb_stb;

   assign bin_sel   = wb_adr[BIN_ADDR_WIDTH];
   assign ctrl_sel  = !bin_sel && (wb_adr[BIN_ADDR_WIDTH-1:0] == REG_CTRL[BIN_ADDR_WIDTH-1:0]);
   assign count_sel = !bin_sel && (wb_adr[BIN_ADDR_WIDTH-1:0] == REG_COUNT[BIN_ADDR_WIDTH-1:0]);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= wb_idle;
      end else begin
         case (state)
            wb_idle:         if (wb_cyc && wb_stb) state <= hist_pkg::wb_ack;
            hist_pkg::wb_ack: state <= wb_idle;  // Ack lasts exactly one cycle
            default:         state <= wb_idle;
         endcase
      end
   end

   assign wb_ack = (state == hist_pkg::wb_ack);

   always_ff @(posedge clk) begin
      if (rst) begin
         enable <= 1'b0;
         shift  <= '0;
      end else if (access && wb_we && ctrl_sel) begin
         enable <= wb_dat_w[CTRL_ENABLE_BIT];
         shift  <= wb_dat_w[CTRL_SHIFT_LSB +: SHIFT_WIDTH];
      end
   end

   // Clearing takes priority over a sample that lands in the same cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         sample_count <= '0;
      end else if (access && wb_we && count_sel) begin
         sample_count <= '0;
      end else if (sample_taken) begin
         sample_count <= sample_count + 1'b1;
      end
   end

   always_comb begin
      ctrl_word                                    = '0;
      ctrl_word[CTRL_ENABLE_BIT]                   = enable;
      ctrl_word[CTRL_SHIFT_LSB +: SHIFT_WIDTH]     = shift;
   end

   always_comb begin
      if (bin_sel) begin
         rd_word = WB_DATA_WIDTH'(dbg_rdata);
      end else if (ctrl_sel) begin
         rd_word = ctrl_word;
      end else if (count_sel) begin
         rd_word = sample_count;
      end else begin
         rd_word = '0;  // Unmapped words read as zero
      end
   end

   // Captured at the accepting edge so it is stable for the whole ack cycle
   always_ff @(posedge clk) begin
      if (access) begin
         wb_dat_r <= rd_word;
      end
   end

   // Bin window goes straight to the RAM debug port
   assign dbg_addr  = wb_adr[BIN_ADDR_WIDTH-1:0];
   assign dbg_wdata = wb_dat_w[COUNT_WIDTH-1:0];
   assign dbg_wen   = access && wb_we && bin_sel;

endmodule

`default_nettype wire

// File: verilog/hist_top.sv
`timescale 1ns/100ps
`default_nettype none

module hist_top
   import hist_pkg::*;
#(
   parameter int NUM_BINS     = DEF_NUM_BINS,
   parameter int COUNT_WIDTH  = DEF_COUNT_WIDTH,
   parameter int SAMPLE_WIDTH = DEF_SAMPLE_WIDTH
) (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       sample_valid,
   input  wire logic [SAMPLE_WIDTH-1:0]    sample_data,
   input  wire logic                       wb_cyc,
   input  wire logic                       wb_stb,
   input  wire logic                       wb_we,
   input  wire logic [$clog2(NUM_BINS):0]  wb_adr,
   input  wire logic [WB_DATA_WIDTH-1:0]   wb_dat_w,
   output logic      [WB_DATA_WIDTH-1:0]   wb_dat_r,
   output logic                            wb_ack
);

   localparam int BIN_ADDR_WIDTH = $clog2(NUM_BINS);

   logic                      enable;
   logic [SHIFT_WIDTH-1:0]    shift;
   logic                      sample_taken;
   logic                      bin_valid;
   logic [BIN_ADDR_WIDTH-1:0] bin_index;
   logic [BIN_ADDR_WIDTH-1:0] dbg_addr;
   logic [COUNT_WIDTH-1:0]    dbg_wdata;
   logic                      dbg_wen;
   logic [COUNT_WIDTH-1:0]    dbg_rdata;

   bin_mapper #(
      .NUM_BINS     (NUM_BINS),
      .SAMPLE_WIDTH (SAMPLE_WIDTH)
   ) u_mapper (
      .clk          (clk),
      .rst          (rst),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .enable       (enable),
      .shift        (shift),
      .sample_taken (sample_taken),
      .bin_valid    (bin_valid),
      .bin_index    (bin_index)
   );

   // Counter pipeline, holds the bin RAM
   hist_update #(
      .NUM_BINS    (NUM_BINS),
      .COUNT_WIDTH (COUNT_WIDTH)
   ) u_update (
      .clk       (clk),
      .rst       (rst),
      .bin_valid (bin_valid),
      .bin_index (bin_index),
      .dbg_addr  (dbg_addr),
      .dbg_wdata (dbg_wdata),
      .dbg_wen   (dbg_wen),
      .dbg_rdata (dbg_rdata)
   );

   wb_hist_slave #(
      .NUM_BINS    (NUM_BINS),
      .COUNT_WIDTH (COUNT_WIDTH)
   ) u_slave (
      .clk          (clk),
      .rst          (rst),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .wb_dat_r     (wb_dat_r),
      .wb_ack       (wb_ack),
      .sample_taken (sample_taken),
      .enable       (enable),
      .shift        (shift),
      .dbg_addr     (dbg_addr),
      .dbg_wdata    (dbg_wdata),
      .dbg_wen      (dbg_wen),
      .dbg_rdata    (dbg_rdata)
   );

endmodule

`default_nettype wire

// File: sim/hist_assert.sv
`timescale 1ns/100ps
`default_nettype none

module hist_assert
   import hist_pkg::*;
(
   input wire logic clk,
   input wire logic rst,
   input wire logic wb_cyc,
   input wire logic wb_stb,
   input wire logic wb_ack
);

   // Read by the testbench, which ends the run once this leaves zero
   int unsigned error_count = 0;

   // Handshake state as seen from the bus, ack high means the slave sits in wb_ack
   wb_state_t seen_state;

   always_comb begin
      if (wb_ack) begin
         seen_state = hist_pkg::wb_ack;
      end else begin
         seen_state = wb_idle;
      end
   end

   // An acknowledge only answers a live strobe
   ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
      wb_ack |-> (wb_cyc && wb_stb))
   else begin
      $error("wb_ack is high without wb_cyc and wb_stb");
      error_count++;
   end

   ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
      wb_ack |=> !wb_ack)
   else begin
      $error("wb_ack stayed high for two cycles");
      error_count++;
   end

   // Fixed latency of one cycle from strobe to acknowledge
   stb_gets_ack: assert property (@(posedge clk) disable iff (rst)
      (wb_cyc && wb_stb && seen_state == wb_idle) |=> wb_ack)
   else begin
      $error("wb_stb in the idle state was not acknowledged on the next cycle");
      error_count++;
   end

   reset_clears_ack: assert property (@(posedge clk)
      rst |=> !wb_ack)
   else begin
      $error("wb_ack is high in the cycle after reset");
      error_count++;
   end

endmodule

bind hist_top hist_assert u_assert (
   .clk    (clk),
   .rst    (rst),
   .wb_cyc (wb_cyc),
   .wb_stb (wb_stb),
   .wb_ack (wb_ack)
);

`default_nettype wire

// File: sim/hist_tb.sv
`timescale 1ns/100ps
`default_nettype none

module hist_tb
   import hist_pkg::*;
();

   localparam int NUM_BINS       = 16;
   localparam int COUNT_WIDTH    = 8;
   localparam int SAMPLE_WIDTH   = 12;
   localparam int BIN_ADDR_WIDTH = $clog2(NUM_BINS);
   localparam int MAX_COUNT      = 2**COUNT_WIDTH - 1;
   localparam int CLK_PERIOD     = 40;

   // The watchdog limit follows from the length of the test sequence below
   localparam longint N_SAMPLES  = 300 + 200 + 300 + 100 + 40;
   localparam longint N_ACCESSES = 34 + 18 + 18 + 3 + 20 + 20;
   localparam longint TIMEOUT_NS = (N_SAMPLES + 12 * N_ACCESSES + 200) * CLK_PERIOD;

   logic                      clk;
   logic                      rst;
   logic                      sample_valid;
   logic [SAMPLE_WIDTH-1:0]   sample_data;
   logic                      wb_cyc;
   logic                      wb_stb;
   logic                      wb_we;
   logic [BIN_ADDR_WIDTH:0]   wb_adr;
   logic [WB_DATA_WIDTH-1:0]  wb_dat_w;
   logic [WB_DATA_WIDTH-1:0]  wb_dat_r;
   logic                      wb_ack;

   // Expected state of the histogram
   int unsigned exp_bins [NUM_BINS];
   int unsigned exp_total;
   logic        model_enable;
   int unsigned model_shift;

   hist_top #(
      .NUM_BINS     (NUM_BINS),
      .COUNT_WIDTH  (COUNT_WIDTH),
      .SAMPLE_WIDTH (SAMPLE_WIDTH)
   ) i_dut (
      .clk          (clk),
      .rst          (rst),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .wb_dat_r     (wb_dat_r),
      .wb_ack       (wb_ack)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the test sequence did not finish in time");
      $display("Simulation failed");
      $fatal(1, "Watchdog expired");
   end

   // A protocol assertion in the bound checker ends the run here
   always @(negedge clk) begin
      if (i_dut.u_assert.error_count != 0) begin
         $display("A Wishbone protocol assertion failed");
         $display("Simulation failed");
         $fatal(1, "Protocol assertion failed");
      end
   end

   function automatic int unsigned bin_of_sample(input int unsigned data, input int unsigned sh);
      int unsigned b;
      b = data >> sh;
      if (b >= NUM_BINS) b = NUM_BINS - 1;  // Clamp to the top bin
      return b;
   endfunction

   function automatic logic [BIN_ADDR_WIDTH:0] bin_address(input int unsigned idx);
      return (BIN_ADDR_WIDTH+1)'((1 << BIN_ADDR_WIDTH) + idx);
   endfunction

   task automatic check_value(input string what, input int unsigned expected,
                              input logic [WB_DATA_WIDTH-1:0] actual);
      assert (actual == expected) else begin
         $display("Fail at %0d ns: %s expected %0d, read %0d", $time, what, expected, actual);
         $display("Simulation failed");
         $fatal(1, "Value mismatch");
      end
   endtask

   // One classic cycle. Strobe stays up through the ack cycle and drops after it
   task automatic bus_cycle(input logic we, input logic [BIN_ADDR_WIDTH:0] adr,
                            input logic [WB_DATA_WIDTH-1:0] wdata,
                            output logic [WB_DATA_WIDTH-1:0] rdata);
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      rdata = wb_dat_r;
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_write(input logic [BIN_ADDR_WIDTH:0] adr, input int unsigned data);
      logic [WB_DATA_WIDTH-1:0] unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   task automatic read_check(input logic [BIN_ADDR_WIDTH:0] adr, input string what,
                             input int unsigned expected);
      logic [WB_DATA_WIDTH-1:0] rd;
      bus_cycle(1'b0, adr, '0, rd);
      check_value(what, expected, rd);
   endtask

   task automatic check_all_bins();
      for (int i = 0; i < NUM_BINS; i++) begin
         read_check(bin_address(i), $sformatf("bin %0d", i), exp_bins[i]);
      end
   endtask

   task automatic check_total();
      read_check(REG_COUNT, "REG_COUNT", exp_total);
   endtask

   task automatic set_ctrl(input logic en, input int unsigned sh);
      bus_write(REG_CTRL, (sh << CTRL_SHIFT_LSB) | int'(en));
      model_enable = en;
      model_shift  = sh;
   endtask

   task automatic drive_sample(input logic valid, input int unsigned data);
      int unsigned b;
      @(negedge clk);
      sample_valid = valid;
      sample_data  = data[SAMPLE_WIDTH-1:0];
      if (valid && model_enable) begin
         b = bin_of_sample(data % (1 << SAMPLE_WIDTH), model_shift);
         if (exp_bins[b] < MAX_COUNT) exp_bins[b]++;  // Counters saturate
         exp_total++;
      end
   endtask

   // Lets the last sample drain out of the update pipeline
   task automatic idle_cycles();
      @(negedge clk);
      sample_valid = 1'b0;
      sample_data  = '0;
      repeat (5) @(negedge clk);
   endtask

   initial begin
      int unsigned value;
      int unsigned run;
      int          sent;

      void'($urandom(53134));
      rst          = 1'b1;
      sample_valid = 1'b0;
      sample_data  = '0;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      foreach (exp_bins[i]) exp_bins[i] = 0;
      exp_total    = 0;
      model_enable = 1'b0;
      model_shift  = 0;
      repeat (3) @(negedge clk);
      rst = 1'b0;

      // Check the registers after reset and clear every bin
      read_check(REG_CTRL, "REG_CTRL", 0);
      check_total();
      for (int i = 0; i < NUM_BINS; i++) bus_write(bin_address(i), 0);
      check_all_bins();

      // Runs of equal values hit the same bin back to back
      set_ctrl(1'b1, 0);
      sent = 0;
      while (sent < 300) begin
         value = $urandom % NUM_BINS;
         run   = 1 + $urandom % 4;
         repeat (run) begin
            if (sent < 300) begin
               drive_sample(1'b1, value);
               sent++;
            end
         end
         if ($urandom % 8 == 0) drive_sample(1'b0, $urandom);  // Gap with junk data
      end
      idle_cycles();
      check_all_bins();
      check_total();

      // With shift 4 the large samples pile up in the last bin
      set_ctrl(1'b1, 4);
      repeat (200) begin
         if ($urandom % 2 == 0) value = $urandom % 256;
         else value = $urandom % 4096;
         drive_sample(1'b1, value);
      end
      idle_cycles();
      check_all_bins();
      check_total();

      // Saturation of one bin
      set_ctrl(1'b1, 0);
      repeat (300) drive_sample(1'b1, 3);
      idle_cycles();
      read_check(bin_address(3), "bin 3", exp_bins[3]);
      check_total();

      // Samples on a disabled input are dropped and a write clears the sample counter
      set_ctrl(1'b0, 0);
      repeat (100) drive_sample(1'b1, $urandom);
      idle_cycles();
      check_all_bins();
      check_total();
      bus_write(REG_COUNT, 0);
      exp_total = 0;
      check_total();

      // Preload a bin and keep counting on top of it
      value = $urandom % 200;
      bus_write(bin_address(5), value);
      exp_bins[5] = value;
      read_check(bin_address(5), "bin 5", exp_bins[5]);
      set_ctrl(1'b1, 0);
      repeat (40) drive_sample(1'b1, ($urandom % 2 == 0) ? 5 : $urandom % NUM_BINS);
      idle_cycles();
      check_all_bins();
      check_total();

      if (i_dut.u_assert.error_count == 0) begin
         $display("Simulation passed");
         $finish;
      end else begin
         $display("Simulation failed");
         $fatal(1, "Protocol assertion failed");
      end
   end

endmodule

`default_nettype wire

// File: tb.f
common/hist_pkg.sv
hist_ram/fwd_hist_ram.sv
verilog/bin_mapper.sv
verilog/hist_update.sv
verilog/wb_hist_slave.sv
verilog/hist_top.sv
sim/hist_assert.sv
sim/hist_tb.sv
